// File: src.f
+incdir+sim
rtl/muldiv_pkg.sv
rtl/mult_pipe.sv
rtl/div_core.sv
rtl/signed_div.sv
rtl/muldiv_unit.sv
sim/muldiv_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module muldiv_tb -o muldiv_sim \
  && ./obj_dir/muldiv_sim | tee /dev/stderr | grep -q "Regression passed" \
  && echo "Simulation finished cleanly" \
  || { echo "Simulation did not pass"; exit 1; }

// File: sim/muldiv_ref.svh
// Reference models and the compare task for the multiply/divide testbench
// Included inside muldiv_tb, which owns lcg_state
// The division model expects a non-zero divisor

// LCG step, halves swapped so the low bits vary well
function automatic muldiv_pkg::data_t next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return {lcg_state[15:0], lcg_state[31:16]};
endfunction

// Full double-width product, operands extended by signedness
function automatic muldiv_pkg::product_t full_product(input muldiv_pkg::data_t a,
                                                       input muldiv_pkg::data_t b,
                                                       input logic sgn);
  logic signed [2*muldiv_pkg::data_width-1:0] sa;
  logic signed [2*muldiv_pkg::data_width-1:0] sb;
  muldiv_pkg::product_t                       ua;
  muldiv_pkg::product_t                       ub;
  sa = $signed(a);
  sb = $signed(b);
  ua = a;
  ub = b;
  if (sgn) begin
    return sa * sb;
  end
  return ua * ub;
endfunction

// Quotient and remainder by the magnitude rule
task automatic expected_division(input muldiv_pkg::data_t a, input muldiv_pkg::data_t b,
                                 input logic sgn, output muldiv_pkg::data_t q,
                                 output muldiv_pkg::data_t r);
  muldiv_pkg::data_t mag_a;
  muldiv_pkg::data_t mag_b;
  muldiv_pkg::data_t t0;
  muldiv_pkg::data_t t1;
  logic              neg_a;
  logic              neg_b;
  neg_a = sgn && a[muldiv_pkg::data_width-1];
  neg_b = sgn && b[muldiv_pkg::data_width-1];
  mag_a = neg_a ? -a : a;
  mag_b = neg_b ? -b : b;
  q     = mag_a / mag_b;
  t0    = mag_a % mag_b;
  if (neg_a != neg_b) begin
    q = -q;
  end
  t1 = ((neg_a != neg_b) && (t0 != '0)) ? mag_b - t0 : t0;
  r  = neg_b ? -t1 : t1;
endtask

task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
  if (actual !== expected) begin
    $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
    $display("Regression failed");
    $fatal(1);
  end
endtask

// File: sim/muldiv_tb.sv
// Directed testbench for the multiply/divide unit
// Multiplies issue back to back, divides hold go until div_done
// Signed division never uses a zero or most negative divisor

`timescale 1ns/1ps

module muldiv_tb;

  localparam int num_mul      = 20;
  localparam int num_udiv     = 12;
  localparam int sdiv_per_mix = 3;
  localparam int num_edge     = 5;
  // Cycle budget for one operation of either kind
  localparam int op_cycles    = 40;
  localparam int timeout_limit =
    (2 * num_mul + num_udiv + 4 * sdiv_per_mix + num_edge + 2) * op_cycles + 100;

  logic                 clk;
  logic                 reset;
  logic                 go;
  muldiv_pkg::op_e      op;
  logic                 is_signed;
  muldiv_pkg::data_t    left;
  muldiv_pkg::data_t    right;
  muldiv_pkg::product_t product;
  muldiv_pkg::data_t    quotient;
  muldiv_pkg::data_t    remainder;
  logic                 mul_done;
  logic                 div_done;
  muldiv_pkg::data_t    lcg_state;
  int                   cycle_count;

  `include "muldiv_ref.svh"

  muldiv_unit u_dut (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .op        (op),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .product   (product),
    .quotient  (quotient),
    .remainder (remainder),
    .mul_done  (mul_done),
    .div_done  (div_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
    $display("Regression failed");
    $fatal(1);
  end

  task automatic reset_check();
    repeat (4) begin
      @(negedge clk);
      check_equal(mul_done, 1'b0, "mul_done after reset");
      check_equal(div_done, 1'b0, "div_done after reset");
      check_equal(product, '0, "product after reset");
    end
  endtask

  // Strobes on consecutive cycles, each done exactly mult_latency edges later
  task automatic mult_burst(input logic sgn, input int n);
    muldiv_pkg::data_t    a_list [$];
    muldiv_pkg::data_t    b_list [$];
    muldiv_pkg::product_t exp_list [$];
    muldiv_pkg::data_t    corner_a [4];
    muldiv_pkg::data_t    corner_b [4];
    muldiv_pkg::data_t    a;
    muldiv_pkg::data_t    b;
    int                   lat;
    int                   i;
    int                   c;
    lat      = muldiv_pkg::mult_latency;
    corner_a = '{32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000};
    corner_b = '{32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff};
    for (i = 0; i < n; i++) begin
      a = (i < 4) ? corner_a[i] : next_rand();
      b = (i < 4) ? corner_b[i] : next_rand();
      a_list.push_back(a);
      b_list.push_back(b);
      exp_list.push_back(full_product(a, b, sgn));
    end
    for (c = 0; c <= n + lat; c++) begin
      @(posedge clk);
      if (c < n) begin
        go        <= 1'b1;
        op        <= muldiv_pkg::op_mul;
        is_signed <= sgn;
        left      <= a_list[c];
        right     <= b_list[c];
      end else begin
        go <= 1'b0;
      end
      @(negedge clk);
      check_equal(mul_done, (c >= lat) && (c - lat < n), "mul_done timing");
      if ((c >= lat) && (c - lat < n)) begin
        check_equal(product, exp_list[c - lat], "product");
      end
    end
  endtask

  // One division with go held until div_done, then a hold check
  task automatic division_op(input muldiv_pkg::data_t a, input muldiv_pkg::data_t b,
                             input logic sgn, input muldiv_pkg::data_t exp_q,
                             input muldiv_pkg::data_t exp_r, output int waited);
    waited = 0;
    @(posedge clk);
    go        <= 1'b1;
    op        <= muldiv_pkg::op_div;
    is_signed <= sgn;
    left      <= a;
    right     <= b;
    @(negedge clk);
    while (!div_done && waited < op_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!div_done) begin
      $display("Division of %h by %h never raised div_done", a, b);
      $display("Regression failed");
      $fatal(1);
    end
    check_equal(quotient, exp_q, "quotient");
    check_equal(remainder, exp_r, "remainder");
    @(posedge clk);
    go <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_equal(div_done, 1'b0, "div_done pulse width");
      check_equal(quotient, exp_q, "held quotient");
      check_equal(remainder, exp_r, "held remainder");
    end
  endtask

  task automatic unsigned_div_test();
    muldiv_pkg::data_t a;
    muldiv_pkg::data_t b;
    muldiv_pkg::data_t q;
    muldiv_pkg::data_t r;
    muldiv_pkg::data_t shift;
    int                waited;
    int                i;
    for (i = 0; i < num_udiv; i++) begin
      a     = next_rand();
      shift = next_rand() % 32;
      b     = next_rand() >> shift;
      if (b == '0) begin
        b = 32'd1;
      end
      expected_division(a, b, 1'b0, q, r);
      division_op(a, b, 1'b0, q, r, waited);
    end
  endtask

  // Bit 1 of mix negates the dividend, bit 0 the divisor
  task automatic signed_div_test();
    muldiv_pkg::data_t a;
    muldiv_pkg::data_t b;
    muldiv_pkg::data_t q;
    muldiv_pkg::data_t r;
    muldiv_pkg::data_t shift;
    int                waited;
    int                mix;
    int                k;
    for (mix = 0; mix < 4; mix++) begin
      for (k = 0; k < sdiv_per_mix; k++) begin
        a     = next_rand() & 32'h7fff_ffff;
        shift = next_rand() % 31;
        b     = (next_rand() & 32'h7fff_ffff) >> shift;
        if (b == '0) begin
          b = 32'd3;
        end
        a = mix[1] ? -a : a;
        b = mix[0] ? -b : b;
        expected_division(a, b, 1'b1, q, r);
        division_op(a, b, 1'b1, q, r, waited);
      end
    end
  endtask

  task automatic edge_case_test();
    muldiv_pkg::data_t q;
    muldiv_pkg::data_t r;
    int                waited;
    // Zero dividend finishes on the edge that samples go
    division_op(32'd0, 32'd5, 1'b0, 32'd0, 32'd0, waited);
    check_equal(waited, 1, "zero dividend latency");
    division_op(32'd0, 32'hffff_fff9, 1'b1, 32'd0, 32'd0, waited);
    check_equal(waited, 1, "signed zero dividend latency");
    division_op(32'h1234_5678, 32'd0, 1'b0, 32'hffff_ffff, 32'h1234_5678, waited);
    expected_division(32'hffff_ffff, 32'd1, 1'b0, q, r);
    division_op(32'hffff_ffff, 32'd1, 1'b0, q, r, waited);
    expected_division(32'd7, 32'hffff_fffe, 1'b1, q, r);
    division_op(32'd7, 32'hffff_fffe, 1'b1, q, r, waited);
  endtask

  initial begin
    lcg_state = 32'd65;
    reset     = 1'b1;
    go        = 1'b0;
    op        = muldiv_pkg::op_mul;
    is_signed = 1'b0;
    left      = '0;
    right     = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    reset_check();
    mult_burst(1'b0, num_mul);
    mult_burst(1'b1, num_mul);
    unsigned_div_test();
    signed_div_test();
    edge_case_test();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: rtl/muldiv_unit.sv
// Integer multiply and divide unit
// Multiply go is a per-operand strobe, divide go is a held level
// No multiply may be started while a division is running
// Results hold until the next result of the same kind

`timescale 1ns/1ps

module muldiv_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 go,
  input  muldiv_pkg::op_e      op,
  input  logic                 is_signed,
  input  muldiv_pkg::data_t    left,
  input  muldiv_pkg::data_t    right,
  output muldiv_pkg::product_t product,
  output muldiv_pkg::data_t    quotient,
  output muldiv_pkg::data_t    remainder,
  output logic                 mul_done,
  output logic                 div_done
);

  logic mul_go;
  logic div_go;

  // Steer go to the engine selected by op
  assign mul_go = go && (op == muldiv_pkg::op_mul);
  assign div_go = go && (op == muldiv_pkg::op_div);

  mult_pipe u_mult (
    .clk       (clk),
    .reset     (reset),
    .go        (mul_go),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .product   (product),
    .done      (mul_done)
  );

  signed_div u_div (
    .clk       (clk),
    .reset     (reset),
    .go        (div_go),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .quotient  (quotient),
    .remainder (remainder),
    .done      (div_done)
  );

endmodule

// File: rtl/signed_div.sv
// Signed or unsigned division around the unsigned div_core
// Signed mode divides magnitudes and fixes the signs afterwards;
// the remainder takes the sign of the divisor
// The most negative operand and a zero divisor are not defined in signed mode

`timescale 1ns/1ps

module signed_div (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  logic              is_signed,
  input  muldiv_pkg::data_t left,
  input  muldiv_pkg::data_t right,
  output muldiv_pkg::data_t quotient,
  output muldiv_pkg::data_t remainder,
  output logic              done
);

  muldiv_pkg::data_t left_mag;
  muldiv_pkg::data_t right_mag;
  muldiv_pkg::data_t raw_quot;
  muldiv_pkg::data_t raw_rem;
  muldiv_pkg::data_t right_save;
  muldiv_pkg::data_t rem_fix;

  logic left_neg;
  logic right_neg;
  logic left_sign;
  logic right_sign;
  logic diff_signs;

  // Unsigned operands never count as negative, so they pass untouched
  assign left_neg  = is_signed && left[muldiv_pkg::data_width-1];
  assign right_neg = is_signed && right[muldiv_pkg::data_width-1];
  assign left_mag  = left_neg ? -left : left;
  assign right_mag = right_neg ? -right : right;

  // Signs are kept for the output fix after go drops
  always_ff @(posedge clk) begin
    if (reset) begin
      left_sign  <= 1'b0;
      right_sign <= 1'b0;
    end else if (go) begin
      left_sign  <= left_neg;
      right_sign <= right_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      right_save <= right_mag;
    end
  end

  div_core u_core (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .dividend  (left_mag),
    .divisor   (right_mag),
    .quotient  (raw_quot),
    .remainder (raw_rem),
    .done      (done)
  );

  assign diff_signs = left_sign ^ right_sign;
  assign quotient   = diff_signs ? -raw_quot : raw_quot;

  // Fold a non-zero remainder over when the signs differ,
  // then give it the divisor's sign
  assign rem_fix   = (diff_signs && (raw_rem != '0)) ? right_save - raw_rem : raw_rem;
  assign remainder = right_sign ? -rem_fix : rem_fix;

  a_signed_stable: assert property (
    @(posedge clk) disable iff (reset) go && $past(go) |-> $stable(is_signed)
  ) else $error("signed_div: is_signed changed during a division");

endmodule

// File: rtl/div_core.sv
// Unsigned restoring divider, one quotient bit per cycle
// go is a level held with stable operands until done; it must drop
// before the next division is accepted
// A zero divisor gives an all-ones quotient and the dividend as remainder

`timescale 1ns/1ps

module div_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  muldiv_pkg::data_t dividend,
  input  muldiv_pkg::data_t divisor,
  output muldiv_pkg::data_t quotient,
  output muldiv_pkg::data_t remainder,
  output logic              done
);

  // Working registers
  muldiv_pkg::data_t                        rem_q;
  muldiv_pkg::data_t                        quot_q;
  muldiv_pkg::data_t                        mask;
  logic [2*muldiv_pkg::data_width-2:0]      div_sh;
  logic [2*muldiv_pkg::data_width-2:0]      rem_wide;
  muldiv_pkg::div_count_t                   cycle_cnt;

  logic running;
  logic hold;
  logic start;
  logic finished;
  logic zero_dividend;
  logic fits;

  // hold blocks a restart until go has been seen low after a result
  assign start         = go && !running && !hold;
  assign zero_dividend = start && (dividend == '0);
  assign finished      = running && (mask == '0);

  assign rem_wide = {{(muldiv_pkg::data_width-1){1'b0}}, rem_q};
  assign fits     = (div_sh <= rem_wide);

  always_ff @(posedge clk) begin
    if (reset || finished || zero_dividend) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hold <= 1'b0;
    end else if (finished || zero_dividend) begin
      hold <= 1'b1;
    end else if (!go) begin
      hold <= 1'b0;
    end
  end

  // Shift-and-subtract datapath
  always_ff @(posedge clk) begin
    if (start) begin
      rem_q  <= dividend;
      quot_q <= '0;
      mask   <= {1'b1, {(muldiv_pkg::data_width-1){1'b0}}};
      div_sh <= {divisor, {(muldiv_pkg::data_width-1){1'b0}}};
    end else if (running) begin
      if (fits) begin
        // Upper bits of div_sh are zero whenever it fits
        rem_q  <= rem_q - div_sh[muldiv_pkg::data_width-1:0];
        quot_q <= quot_q | mask;
      end
      mask   <= mask >> 1;
      div_sh <= div_sh >> 1;
    end
  end

  // Results stay put until the next division completes
  always_ff @(posedge clk) begin
    if (reset) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (zero_dividend) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (finished) begin
      quotient  <= quot_q;
      remainder <= rem_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= finished || zero_dividend;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cycle_cnt <= '0;
    end else if (running) begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  a_go_held: assert property (
    @(posedge clk) disable iff (reset) running |-> go
  ) else $error("div_core: go dropped during a division");

  a_no_start_on_done: assert property (
    @(posedge clk) disable iff (reset) start |-> !done
  ) else $error("div_core: new division started while done was high");

  // One shift step per data bit, plus the finishing cycle
  a_bounded_run: assert property (
    @(posedge clk) disable iff (reset)
      running |-> cycle_cnt <= muldiv_pkg::div_count_t'(muldiv_pkg::data_width)
  ) else $error("div_core: division ran past its step count");

endmodule

// File: rtl/mult_pipe.sv
// Two-stage integer multiplier, signed or unsigned per operand pair
// go is a one-cycle strobe and may be high on consecutive cycles
// done pulses mult_latency edges after the strobe, results in order

`timescale 1ns/1ps

module mult_pipe (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   go,
  input  logic                   is_signed,
  input  muldiv_pkg::data_t      left,
  input  muldiv_pkg::data_t      right,
  output muldiv_pkg::product_t   product,
  output logic                   done
);

  muldiv_pkg::data_t    left_q;
  muldiv_pkg::data_t    right_q;
  logic                 signed_q;
  muldiv_pkg::product_t left_ext;
  muldiv_pkg::product_t right_ext;
  muldiv_pkg::product_t full_prod;

  // One valid bit per stage travels with each operand pair
  logic [muldiv_pkg::mult_latency-1:0] valid;

  // Stage 1 captures the operands and the signed flag on a strobe
  always_ff @(posedge clk) begin
    if (go) begin
      left_q   <= left;
      right_q  <= right;
      signed_q <= is_signed;
    end
  end

  // Extend both operands to product width before the multiply
  always_comb begin
    if (signed_q) begin
      left_ext  = {{muldiv_pkg::data_width{left_q[muldiv_pkg::data_width-1]}}, left_q};
      right_ext = {{muldiv_pkg::data_width{right_q[muldiv_pkg::data_width-1]}}, right_q};
    end else begin
      left_ext  = {{muldiv_pkg::data_width{1'b0}}, left_q};
      right_ext = {{muldiv_pkg::data_width{1'b0}}, right_q};
    end
    // Low half of the wide product is exact for both signednesses
    full_prod = left_ext * right_ext;
  end

  // Stage 2 holds the product until the next valid item replaces it
  always_ff @(posedge clk) begin
    if (reset) begin
      product <= '0;
    end else if (valid[0]) begin
      product <= full_prod;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      valid <= {valid[muldiv_pkg::mult_latency-2:0], go};
    end
  end

  assign done = valid[muldiv_pkg::mult_latency-1];

  // Nothing in flight may leak through a reset
  a_no_done_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> !done ##1 !done
  ) else $error("mult_pipe: done high right after reset");

endmodule

// File: rtl/muldiv_pkg.sv
// Shared widths and types for the multiply/divide unit
// Operand width is fixed here and is not a module parameter
// Products are always returned at full double width

package muldiv_pkg;

  // Operand, quotient and remainder width
  localparam int data_width = 32;

  // Rising edges from a multiply strobe to its done pulse
  localparam int mult_latency = 2;

  // One operand, quotient or remainder
  typedef logic [data_width-1:0] data_t;

  // Full double-width product
  typedef logic [2*data_width-1:0] product_t;

  // Operation select at the top level
  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } op_e;

  // Wide enough to count every shift step of one division
  typedef logic [$clog2(data_width):0] div_count_t;

endpackage
